/* design/duel_geometry_pkg.sv */
package duel_geometry_pkg;

	typedef logic [7:0] coord_t;

	typedef enum logic {
		P1,  // Right side, shoots left
		P2   // Left side, shoots right
	} side_t;

	localparam coord_t SCREEN_W = 8'd160;
	localparam coord_t SCREEN_H = 8'd120;

	localparam coord_t TANK_W   = 8'd8;
	localparam coord_t TANK_H   = 8'd16;
	localparam coord_t GUN_W    = 8'd4;
	localparam coord_t GUN_H    = 8'd2;
	localparam coord_t BULLET_W = 8'd4;
	localparam coord_t BULLET_H = 8'd2;
	localparam coord_t GUN_DY   = 8'd3;  // Gun below tank top

	localparam coord_t START_Y    = 8'd50;
	localparam coord_t P1_START_X = 8'd144;
	localparam coord_t P1_MIN_X   = 8'd123;
	localparam coord_t P1_MAX_X   = 8'd144;
	localparam coord_t P2_START_X = 8'd8;
	localparam coord_t P2_MIN_X   = 8'd8;
	localparam coord_t P2_MAX_X   = 8'd30;
	localparam coord_t MIN_Y      = 8'd10;
	localparam coord_t MAX_Y      = 8'd100;

	localparam coord_t BULLET_MIN_X = 8'd0;    // P1 bullet turns here
	localparam coord_t BULLET_MAX_X = 8'd150;  // P2 bullet turns here

endpackage

/* design/duel_control_pkg.sv */
package duel_control_pkg;

	typedef logic [6:0] key_code_t;

	localparam key_code_t KEY_P1_UP    = 7'h11;
	localparam key_code_t KEY_P1_LEFT  = 7'h12;
	localparam key_code_t KEY_P1_DOWN  = 7'h13;
	localparam key_code_t KEY_P1_RIGHT = 7'h14;
	localparam key_code_t KEY_P2_UP    = 7'h77;  // w
	localparam key_code_t KEY_P2_LEFT  = 7'h61;  // a
	localparam key_code_t KEY_P2_DOWN  = 7'h73;  // s
	localparam key_code_t KEY_P2_RIGHT = 7'h64;  // d

	typedef logic [2:0] colour_t;

	localparam colour_t COLOUR_BLACK = 3'd0;
	localparam colour_t COLOUR_P2    = 3'd1;
	localparam colour_t COLOUR_P1    = 3'd3;
	localparam colour_t COLOUR_HIT   = 3'd5;

	typedef logic [3:0] bcd_digit_t;
	typedef logic [6:0] segments_t;  // Active low

	typedef struct packed {
		bcd_digit_t tens;
		bcd_digit_t ones;
	} score_t;

	typedef enum logic [1:0] {
		SHAPE_SCREEN,
		SHAPE_TANK,
		SHAPE_GUN,
		SHAPE_BULLET
	} sprite_shape_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} move_cmd_t;

	typedef struct packed {
		duel_geometry_pkg::coord_t tank_x;
		duel_geometry_pkg::coord_t tank_y;
		duel_geometry_pkg::coord_t bullet_x;
		duel_geometry_pkg::coord_t bullet_y;
		logic                      fired;
	} tank_state_t;

	typedef struct packed {
		sprite_shape_t             shape;
		duel_geometry_pkg::coord_t x;
		duel_geometry_pkg::coord_t y;
		colour_t                   colour;
	} sprite_req_t;

	typedef struct packed {
		duel_geometry_pkg::coord_t x;
		duel_geometry_pkg::coord_t y;
		colour_t                   colour;
		logic                      plot;
	} pixel_t;

endpackage

/* design/key_command_decoder.sv */
`timescale 1ns/1ps

module key_command_decoder (
	input  logic                          CLOCK_50,
	input  logic                          rst_n,
	input  duel_control_pkg::key_code_t   key_code,
	input  logic                          fire_p1,
	input  logic                          fire_p2,
	output duel_control_pkg::move_cmd_t   cmd_p1,
	output duel_control_pkg::move_cmd_t   cmd_p2
);
	import duel_control_pkg::*;

	// Only one key is held at a time, unknown codes match nothing
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			cmd_p1 <= '0;
			cmd_p2 <= '0;
		end else begin
			cmd_p1.up    <= (key_code == KEY_P1_UP);
			cmd_p1.down  <= (key_code == KEY_P1_DOWN);
			cmd_p1.left  <= (key_code == KEY_P1_LEFT);
			cmd_p1.right <= (key_code == KEY_P1_RIGHT);
			cmd_p1.fire  <= fire_p1;
			cmd_p2.up    <= (key_code == KEY_P2_UP);
			cmd_p2.down  <= (key_code == KEY_P2_DOWN);
			cmd_p2.left  <= (key_code == KEY_P2_LEFT);
			cmd_p2.right <= (key_code == KEY_P2_RIGHT);
			cmd_p2.fire  <= fire_p2;
		end
	end

endmodule

/* design/tank_motion.sv */
`timescale 1ns/1ps

module tank_motion #(
	parameter duel_geometry_pkg::side_t SIDE = duel_geometry_pkg::P1
) (
	input  logic                           CLOCK_50,
	input  logic                           rst_n,
	input  logic                           step,
	input  duel_control_pkg::move_cmd_t    cmd,
	input  duel_control_pkg::tank_state_t  opponent,
	output duel_control_pkg::tank_state_t  state,
	output duel_control_pkg::score_t       score,
	output logic                           scored
);
	import duel_geometry_pkg::*;
	import duel_control_pkg::*;

	localparam coord_t START_X = (SIDE == P1) ? P1_START_X : P2_START_X;
	localparam coord_t MIN_X   = (SIDE == P1) ? P1_MIN_X : P2_MIN_X;
	localparam coord_t MAX_X   = (SIDE == P1) ? P1_MAX_X : P2_MAX_X;
	localparam coord_t TURN_X  = (SIDE == P1) ? BULLET_MIN_X : BULLET_MAX_X;

	tank_state_t nxt;
	logic        reload;
	logic        hit;

	// Gun hangs off the side facing the opponent
	function automatic coord_t gun_x_of(input coord_t tank_x);
		return (SIDE == P1) ? tank_x - GUN_W : tank_x + TANK_W;
	endfunction

	always_comb begin
		nxt = state;
		reload = 1'b0;
		if (cmd.up && state.tank_y > MIN_Y)
			nxt.tank_y = state.tank_y - 8'd1;
		if (cmd.down && state.tank_y < MAX_Y)
			nxt.tank_y = state.tank_y + 8'd1;
		if (cmd.left && state.tank_x > MIN_X)
			nxt.tank_x = state.tank_x - 8'd1;
		if (cmd.right && state.tank_x < MAX_X)
			nxt.tank_x = state.tank_x + 8'd1;
		if (!state.fired) begin  // Resting bullet rides on the gun
			nxt.bullet_x = gun_x_of(nxt.tank_x);
			nxt.bullet_y = nxt.tank_y + GUN_DY;
		end
		if (cmd.fire)
			nxt.fired = 1'b1;
		if (nxt.fired) begin
			if (nxt.bullet_x == TURN_X)
				reload = 1'b1;
			else if (SIDE == P1)
				nxt.bullet_x = nxt.bullet_x - 8'd1;
			else
				nxt.bullet_x = nxt.bullet_x + 8'd1;
		end
		// Rectangle overlap against the opponent tank before its step
		hit = nxt.fired && !reload &&
			(nxt.bullet_x < opponent.tank_x + TANK_W) &&
			(opponent.tank_x < nxt.bullet_x + BULLET_W) &&
			(nxt.bullet_y < opponent.tank_y + TANK_H) &&
			(opponent.tank_y < nxt.bullet_y + BULLET_H);
		if (reload || hit) begin
			nxt.bullet_x = gun_x_of(nxt.tank_x);
			nxt.bullet_y = nxt.tank_y + GUN_DY;
			nxt.fired = 1'b0;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state.tank_x   <= START_X;
			state.tank_y   <= START_Y;
			state.bullet_x <= gun_x_of(START_X);
			state.bullet_y <= START_Y + GUN_DY;
			state.fired    <= 1'b0;
			score          <= '0;
			scored         <= 1'b0;
		end else if (step) begin
			state  <= nxt;
			scored <= hit;  // Held until the next step
			if (hit) begin
				if (score.ones == 4'd9) begin
					score.ones <= 4'd0;
					score.tens <= (score.tens == 4'd9) ? 4'd0 : score.tens + 4'd1;
				end else begin
					score.ones <= score.ones + 4'd1;
				end
			end
		end
	end

	a_bcd_digits: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		score.ones <= 4'd9 && score.tens <= 4'd9);

endmodule

/* design/duel_sequencer.sv */
`timescale 1ns/1ps

module duel_sequencer #(
	parameter int FRAME_TICKS = 833_333
) (
	input  logic                           CLOCK_50,
	input  logic                           rst_n,
	input  duel_control_pkg::tank_state_t  p1,
	input  duel_control_pkg::tank_state_t  p2,
	input  logic                           p1_scored,
	input  logic                           p2_scored,
	input  logic                           ack,
	output logic                           step,
	output logic                           req,
	output duel_control_pkg::sprite_req_t  sprite_req
);
	import duel_geometry_pkg::*;
	import duel_control_pkg::*;

	localparam int TICK_W = $clog2(FRAME_TICKS);

	typedef enum logic [2:0] {
		S_CLEAR,
		S_INIT,
		S_IDLE,
		S_ERASE,
		S_STEP,
		S_DRAW
	} seq_state_t;

	seq_state_t        seq;
	logic [2:0]        idx;  // 0..2 P1 sprites, 3..5 P2 sprites
	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	tank_state_t       who;
	colour_t           own;
	logic              victim;

	assign tick = (tick_cnt == TICK_W'(FRAME_TICKS - 1));
	assign step = (seq == S_STEP);

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n)
			tick_cnt <= '0;
		else
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
	end

	always_comb begin
		who = (idx < 3'd3) ? p1 : p2;
		own = (idx < 3'd3) ? COLOUR_P1 : COLOUR_P2;
		victim = (idx < 3'd3) ? p2_scored : p1_scored;  // Opponent hit this tank
		case (idx)
			3'd0, 3'd3: begin
				sprite_req.shape = SHAPE_TANK;
				sprite_req.x = who.tank_x;
				sprite_req.y = who.tank_y;
				sprite_req.colour = victim ? COLOUR_HIT : own;
			end
			3'd1, 3'd4: begin
				sprite_req.shape = SHAPE_GUN;
				sprite_req.x = (idx == 3'd1) ? who.tank_x - GUN_W : who.tank_x + TANK_W;
				sprite_req.y = who.tank_y + GUN_DY;
				sprite_req.colour = own;
			end
			default: begin
				sprite_req.shape = SHAPE_BULLET;
				sprite_req.x = who.bullet_x;
				sprite_req.y = who.bullet_y;
				sprite_req.colour = own;
			end
		endcase
		if (seq == S_ERASE)
			sprite_req.colour = COLOUR_BLACK;
		if (seq == S_CLEAR) begin
			sprite_req.shape = SHAPE_SCREEN;
			sprite_req.x = 8'd0;
			sprite_req.y = 8'd0;
			sprite_req.colour = COLOUR_BLACK;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			seq <= S_CLEAR;
			idx <= 3'd0;
			req <= 1'b0;
		end else begin
			case (seq)
				S_IDLE: if (tick) seq <= S_ERASE;  // Ticks are only heard here
				S_STEP: seq <= S_DRAW;
				default: begin
					if (!req && !ack) begin
						req <= 1'b1;
					end else if (req && ack) begin
						req <= 1'b0;
						if (seq != S_CLEAR && idx != 3'd5) begin
							idx <= idx + 3'd1;
						end else begin
							idx <= 3'd0;
							case (seq)
								S_CLEAR: seq <= S_INIT;
								S_ERASE: seq <= S_STEP;
								default: seq <= S_IDLE;
							endcase
						end
					end
				end
			endcase
		end
	end

	a_req_held: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		$fell(req) |-> $past(ack));

endmodule

/* design/sprite_plotter.sv */
`timescale 1ns/1ps

module sprite_plotter (
	input  logic                           CLOCK_50,
	input  logic                           rst_n,
	input  logic                           req,
	input  duel_control_pkg::sprite_req_t  sprite_req,
	output logic                           ack,
	output duel_control_pkg::pixel_t       pixel
);
	import duel_geometry_pkg::*;
	import duel_control_pkg::*;

	typedef enum logic [1:0] {
		P_IDLE,
		P_SCAN,
		P_ACK
	} plot_state_t;

	plot_state_t ps;
	coord_t      size_w, size_h;
	coord_t      org_x, org_y, w, h, col, row;
	colour_t     colour;
	logic        last;

	always_comb begin
		case (sprite_req.shape)
			SHAPE_TANK:   begin size_w = TANK_W;   size_h = TANK_H;   end
			SHAPE_GUN:    begin size_w = GUN_W;    size_h = GUN_H;    end
			SHAPE_BULLET: begin size_w = BULLET_W; size_h = BULLET_H; end
			default:      begin size_w = SCREEN_W; size_h = SCREEN_H; end
		endcase
	end

	assign last = (col == w - 8'd1) && (row == h - 8'd1);

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n)
			ps <= P_IDLE;
		else
			case (ps)
				P_IDLE: if (req) ps <= P_SCAN;
				P_SCAN: if (last) ps <= P_ACK;
				default: if (!req) ps <= P_IDLE;  // Wait for req to drop
			endcase
	end

	// Column by column, rows inside each column
	always_ff @(posedge CLOCK_50) begin
		if (ps == P_IDLE && req) begin
			org_x <= sprite_req.x;
			org_y <= sprite_req.y;
			colour <= sprite_req.colour;
			w <= size_w;
			h <= size_h;
			col <= 8'd0;
			row <= 8'd0;
		end else if (ps == P_SCAN) begin
			if (row == h - 8'd1) begin
				row <= 8'd0;
				col <= col + 8'd1;
			end else begin
				row <= row + 8'd1;
			end
		end
	end

	assign ack          = (ps == P_ACK);
	assign pixel.x      = org_x + col;
	assign pixel.y      = org_y + row;
	assign pixel.colour = colour;
	assign pixel.plot   = (ps == P_SCAN);

	a_plot_in_handshake: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		pixel.plot |-> req && !ack);
	a_plot_on_screen: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		pixel.plot |-> pixel.x < SCREEN_W && pixel.y < SCREEN_H);
	a_ack_needs_req: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		$rose(ack) |-> req);

endmodule

/* design/score_display.sv */
`timescale 1ns/1ps

module score_display (
	input  duel_control_pkg::score_t          score_p1,
	input  duel_control_pkg::score_t          score_p2,
	output duel_control_pkg::segments_t [3:0] hex
);
	import duel_control_pkg::*;

	function automatic segments_t seg_of(input bcd_digit_t d);
		segments_t s;
		case (d)
			4'h0: s = 7'b100_0000;
			4'h1: s = 7'b111_1001;
			4'h2: s = 7'b010_0100;
			4'h3: s = 7'b011_0000;
			4'h4: s = 7'b001_1001;
			4'h5: s = 7'b001_0010;
			4'h6: s = 7'b000_0010;
			4'h7: s = 7'b111_1000;
			4'h8: s = 7'b000_0000;
			4'h9: s = 7'b001_1000;
			4'hA: s = 7'b000_1000;
			4'hB: s = 7'b000_0011;
			4'hC: s = 7'b100_0110;
			4'hD: s = 7'b010_0001;
			4'hE: s = 7'b000_0110;
			default: s = 7'b000_1110;  // F
		endcase
		return s;
	endfunction

	assign hex[0] = seg_of(score_p1.ones);
	assign hex[1] = seg_of(score_p1.tens);
	assign hex[2] = seg_of(score_p2.ones);
	assign hex[3] = seg_of(score_p2.tens);

endmodule

/* design/cowboy_gunner_top.sv */
`timescale 1ns/1ps

module cowboy_gunner_top #(
	parameter int FRAME_TICKS = 833_333  // 60 Hz at 50 MHz
) (
	input  logic                              CLOCK_50,
	input  logic                              rst_n,
	input  duel_control_pkg::key_code_t       key_code,
	input  logic                              fire_p1,
	input  logic                              fire_p2,
	output duel_control_pkg::pixel_t          pixel,
	output duel_control_pkg::segments_t [3:0] hex
);
	import duel_geometry_pkg::*;
	import duel_control_pkg::*;

	move_cmd_t   cmd_p1, cmd_p2;
	tank_state_t p1, p2;
	score_t      score_p1, score_p2;
	logic        p1_scored, p2_scored;
	logic        step, req, ack;
	sprite_req_t sprite_req;

	key_command_decoder u_keys (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .key_code(key_code),
		.fire_p1(fire_p1), .fire_p2(fire_p2), .cmd_p1(cmd_p1), .cmd_p2(cmd_p2)
	);

	tank_motion #(.SIDE(P1)) u_p1 (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .step(step), .cmd(cmd_p1),
		.opponent(p2), .state(p1), .score(score_p1), .scored(p1_scored)
	);

	tank_motion #(.SIDE(P2)) u_p2 (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .step(step), .cmd(cmd_p2),
		.opponent(p1), .state(p2), .score(score_p2), .scored(p2_scored)
	);

	duel_sequencer #(.FRAME_TICKS(FRAME_TICKS)) u_seq (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .p1(p1), .p2(p2),
		.p1_scored(p1_scored), .p2_scored(p2_scored), .ack(ack),
		.step(step), .req(req), .sprite_req(sprite_req)
	);

	sprite_plotter u_plot (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .req(req), .sprite_req(sprite_req),
		.ack(ack), .pixel(pixel)
	);

	score_display u_score (
		.score_p1(score_p1), .score_p2(score_p2), .hex(hex)
	);

endmodule

/* testbench/tb_cowboy_gunner.sv */
`timescale 1ns/1ps

module tb_cowboy_gunner;
	import duel_geometry_pkg::*;
	import duel_control_pkg::*;

	localparam int FRAME_TICKS  = 2_000;
	localparam int QUIET_CYCLES = 64;  // Longer than any gap between sprites
	localparam int RISE_FRAMES  = START_Y - MIN_Y;
	localparam int SHOT_FRAMES  = (P1_MIN_X - GUN_W) - (P2_MIN_X + TANK_W) + 1;
	localparam int MISS_FRAMES  = BULLET_MAX_X - (P2_MIN_X + TANK_W) + 4;
	localparam int TOTAL_FRAMES = 12 + 65 + 28 + 3 * RISE_FRAMES + 10 * SHOT_FRAMES + MISS_FRAMES;
	localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES + 40) * FRAME_TICKS * 10;
	localparam key_code_t KEY_NONE = 7'h00;
	localparam segments_t SEG_0 = 7'b100_0000;
	localparam segments_t SEG_1 = 7'b111_1001;

	logic            CLOCK_50;
	logic            rst_n;
	key_code_t       key_code;
	logic            fire_p1;
	logic            fire_p2;
	pixel_t          pixel;
	segments_t [3:0] hex;
	colour_t         fb [SCREEN_W][SCREEN_H];  // Frame buffer model
	int              exp_p1x, exp_p1y, exp_p2x, exp_p2y;
	colour_t         exp_p2_tank;

	cowboy_gunner_top #(.FRAME_TICKS(FRAME_TICKS)) dut_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .key_code(key_code),
		.fire_p1(fire_p1), .fire_p2(fire_p2), .pixel(pixel), .hex(hex)
	);

	initial CLOCK_50 = 1'b0;
	always #5 CLOCK_50 = ~CLOCK_50;

	// Each plot lasts one full cycle, so the falling edge sees it once
	always @(negedge CLOCK_50) begin
		if (pixel.plot && pixel.x < SCREEN_W && pixel.y < SCREEN_H)
			fb[pixel.x][pixel.y] <= pixel.colour;
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			report_fail($sformatf("FAIL %s: got %0h, expected %0h", name, got, exp));
	endtask

	function automatic bit inside_rect(input int x, input int y, input int rx, input int ry,
			input int w, input int h);
		return x >= rx && x < rx + w && y >= ry && y < ry + h;
	endfunction

	function automatic colour_t expected_colour(input int x, input int y);
		colour_t c;
		c = COLOUR_BLACK;
		if (inside_rect(x, y, exp_p1x, exp_p1y, TANK_W, TANK_H))
			c = COLOUR_P1;
		if (inside_rect(x, y, exp_p1x - GUN_W, exp_p1y + GUN_DY, GUN_W, GUN_H))
			c = COLOUR_P1;  // Gun with its resting bullet
		if (inside_rect(x, y, exp_p2x, exp_p2y, TANK_W, TANK_H))
			c = exp_p2_tank;
		if (inside_rect(x, y, exp_p2x + TANK_W, exp_p2y + GUN_DY, GUN_W, GUN_H))
			c = COLOUR_P2;
		return c;
	endfunction

	task automatic check_scene();
		colour_t exp;
		for (int x = 0; x < SCREEN_W; x++) begin
			for (int y = 0; y < SCREEN_H; y++) begin
				exp = expected_colour(x, y);
				assert (fb[x][y] === exp) else
					report_fail($sformatf("FAIL pixel colour at (%0d,%0d): got %h, expected %h",
						x, y, fb[x][y], exp));
			end
		end
	endtask

	task automatic check_hex(input segments_t p1_tens, input segments_t p1_ones,
			input segments_t p2_tens, input segments_t p2_ones);
		check_value("hex[0]", hex[0], p1_ones);
		check_value("hex[1]", hex[1], p1_tens);
		check_value("hex[2]", hex[2], p2_ones);
		check_value("hex[3]", hex[3], p2_tens);
	endtask

	// Returns once the plot stream has paused after a burst
	task automatic wait_frame();
		int quiet;
		@(negedge CLOCK_50);
		while (!pixel.plot)
			@(negedge CLOCK_50);
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge CLOCK_50);
			quiet = pixel.plot ? 0 : quiet + 1;
		end
	endtask

	task automatic drive_inputs(input key_code_t key, input logic f1, input logic f2);
		@(posedge CLOCK_50);
		#1;
		key_code = key;
		fire_p1 = f1;
		fire_p2 = f2;
	endtask

	task automatic hold_for_frames(input key_code_t key, input logic f1, input logic f2,
			input int n);
		drive_inputs(key, f1, f2);
		repeat (n) wait_frame();
		drive_inputs(KEY_NONE, 1'b0, 1'b0);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (10) begin
			@(negedge CLOCK_50);
			assert (!pixel.plot) else
				report_fail("A pixel was plotted while reset was held");
		end
		@(posedge CLOCK_50);
		#1 rst_n = 1'b1;
	endtask

	task automatic test_initial_scene();
		wait_frame();  // Clear and first draw
		check_scene();
		check_hex(SEG_0, SEG_0, SEG_0, SEG_0);
	endtask

	task automatic test_p2_vertical();
		hold_for_frames(KEY_P2_DOWN, 1'b0, 1'b0, 5);
		exp_p2y = START_Y + 5;
		check_scene();
		hold_for_frames(KEY_P2_UP, 1'b0, 1'b0, 60);
		exp_p2y = MIN_Y;
		check_scene();
	endtask

	task automatic test_p1_limits();
		hold_for_frames(KEY_P1_RIGHT, 1'b0, 1'b0, 3);
		check_scene();
		hold_for_frames(KEY_P1_LEFT, 1'b0, 1'b0, 25);
		exp_p1x = P1_MIN_X;
		check_scene();
	endtask

	task automatic test_p1_hit_p2_miss();
		hold_for_frames(KEY_P2_DOWN, 1'b0, 1'b0, RISE_FRAMES);
		exp_p2y = START_Y;
		hold_for_frames(KEY_NONE, 1'b1, 1'b0, 1);
		repeat (SHOT_FRAMES - 2) wait_frame();
		check_hex(SEG_0, SEG_0, SEG_0, SEG_0);  // One frame before contact
		wait_frame();
		check_hex(SEG_0, SEG_1, SEG_0, SEG_0);
		exp_p2_tank = COLOUR_HIT;
		check_scene();
		exp_p2_tank = COLOUR_P2;
		hold_for_frames(KEY_P1_UP, 1'b0, 1'b0, RISE_FRAMES);
		exp_p1y = MIN_Y;
		hold_for_frames(KEY_NONE, 1'b0, 1'b1, 1);
		repeat (MISS_FRAMES - 1) wait_frame();
		check_hex(SEG_0, SEG_1, SEG_0, SEG_0);
		check_scene();
	endtask

	task automatic test_ten_hits();
		hold_for_frames(KEY_P2_UP, 1'b0, 1'b0, RISE_FRAMES);
		exp_p2y = MIN_Y;
		hold_for_frames(KEY_NONE, 1'b1, 1'b0, 9 * SHOT_FRAMES);  // Refires after each hit
		check_hex(SEG_1, SEG_0, SEG_0, SEG_0);
		exp_p2_tank = COLOUR_HIT;
		check_scene();
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_fail("Timeout: the frames did not finish in the expected time");
	end

	initial begin
		rst_n = 1'b0;
		key_code = KEY_NONE;
		fire_p1 = 1'b0;
		fire_p2 = 1'b0;
		exp_p1x = P1_START_X;
		exp_p1y = START_Y;
		exp_p2x = P2_START_X;
		exp_p2y = START_Y;
		exp_p2_tank = COLOUR_P2;
		for (int x = 0; x < SCREEN_W; x++)
			for (int y = 0; y < SCREEN_H; y++)
				fb[x][y] <= colour_t'((x + 3 * y) % 7 + 1);  // Never black
		apply_reset();
		test_initial_scene();
		test_p2_vertical();
		test_p1_limits();
		test_p1_hit_p2_miss();
		test_ten_hits();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* sources.f */
design/duel_geometry_pkg.sv
design/duel_control_pkg.sv
design/key_command_decoder.sv
design/tank_motion.sv
design/duel_sequencer.sv
design/sprite_plotter.sv
design/score_display.sv
design/cowboy_gunner_top.sv
testbench/tb_cowboy_gunner.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cowboy_gunner
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
